// ==== sram_fifo_pkg.sv ====
// shared widths, word layout, queue count and queue mask types
package sram_fifo_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // queue count
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // number of queues sharing the one memory
    localparam int NUM_QUEUES = 4;
    // bits in a queue number, also the upper memory address bits
    localparam int QID_W = $clog2(NUM_QUEUES);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stream word fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int DATA_W = 32;
    localparam int USER_W = 8;
    // last flag + user + data
    localparam int WORD_W = 1 + USER_W + DATA_W;

    // stream data
    typedef logic [DATA_W-1:0] data_t;
    // sideband user bits
    typedef logic [USER_W-1:0] user_t;
    // queue number
    typedef logic [QID_W-1:0] queue_id_t;
    // stored word, msb is last, then user, then data in the low bits
    typedef logic [WORD_W-1:0] word_t;
    // one bit per queue
    typedef logic [NUM_QUEUES-1:0] queue_mask_t;

endpackage

// ==== sram_bank.sv ====
// dual-port storage array with one write port and a registered read port
module sram_bank
#(
    // words per queue region, as log2
    parameter int REGION_LOG2 = 4
)
(
    input  logic                                          memclk,
    input  logic                                          wr_en,
    input  logic [REGION_LOG2+sram_fifo_pkg::QID_W-1:0]   wr_addr,
    input  sram_fifo_pkg::word_t                          wr_word,
    input  logic [REGION_LOG2+sram_fifo_pkg::QID_W-1:0]   rd_addr,
    output sram_fifo_pkg::word_t                          rd_word
);

    // one region per queue, queue number sits in the upper address bits
    localparam int DEPTH = 2 ** (REGION_LOG2 + sram_fifo_pkg::QID_W);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    sram_fifo_pkg::word_t mem [DEPTH];

    // write port
    always_ff @(posedge memclk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_word;
        end
    end

    // read port, data valid one cycle after the address
    always_ff @(posedge memclk)
    begin
        rd_word <= mem[rd_addr];
    end

endmodule

// ==== queue_pointer_ctrl.sv ====
// per-queue head, tail and count tracking; ingress writes and granted reads
module queue_pointer_ctrl
#(
    parameter int REGION_LOG2 = 4
)
(
    input  logic                                          memclk,
    input  logic                                          reset,
    input  logic                                          in_valid,
    input  sram_fifo_pkg::word_t                          in_word,
    input  sram_fifo_pkg::queue_id_t                      in_queue_id,
    input  sram_fifo_pkg::queue_mask_t                    rd_inc,
    output logic                                          in_ready,
    output sram_fifo_pkg::queue_mask_t                    mem_empty,
    output logic                                          mem_wr_en,
    output logic [REGION_LOG2+sram_fifo_pkg::QID_W-1:0]   mem_wr_addr,
    output sram_fifo_pkg::word_t                          mem_wr_word,
    output logic [REGION_LOG2+sram_fifo_pkg::QID_W-1:0]   mem_rd_addr,
    output logic                                          ret_valid,
    output sram_fifo_pkg::queue_id_t                      ret_queue_id
);

    localparam int NQ = sram_fifo_pkg::NUM_QUEUES;
    // a region is full at this many words
    localparam int REGION_WORDS = 2 ** REGION_LOG2;

    logic [REGION_LOG2-1:0] head    [NQ];
    logic [REGION_LOG2-1:0] tail    [NQ];
    logic [REGION_LOG2:0]   count   [NQ];
    logic [REGION_LOG2:0]   cnt_nxt [NQ];
    // registered space flag per region, low during and right after reset
    sram_fifo_pkg::queue_mask_t room;
    sram_fifo_pkg::queue_mask_t push;
    sram_fifo_pkg::queue_id_t   rd_q;
    logic                       wr_fire;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ingress side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign in_ready    = room[in_queue_id];
    assign wr_fire     = in_valid & in_ready;
    assign mem_wr_en   = wr_fire;
    // address is queue number joined with the tail pointer
    assign mem_wr_addr = {in_queue_id, tail[in_queue_id]};
    assign mem_wr_word = in_word;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // rd_inc is one-hot or zero, encode it to a queue number
    always_comb
    begin
        rd_q = '0;
        for (int q = 0; q < NQ; q++)
        begin
            if (rd_inc[q])
            begin
                rd_q = sram_fifo_pkg::queue_id_t'(q);
            end
        end
    end

    assign mem_rd_addr = {rd_q, head[rd_q]};

    // next count per region; push and pop together cancel out
    always_comb
    begin
        for (int q = 0; q < NQ; q++)
        begin
            push[q]      = wr_fire && (in_queue_id == q);
            mem_empty[q] = (count[q] == '0);
            cnt_nxt[q]   = count[q];
            if (push[q] && !rd_inc[q])
            begin
                cnt_nxt[q] = count[q] + 1'b1;
            end
            else if (!push[q] && rd_inc[q])
            begin
                cnt_nxt[q] = count[q] - 1'b1;
            end
        end
    end

    always_ff @(posedge memclk)
    begin
        if (reset)
        begin
            for (int q = 0; q < NQ; q++)
            begin
                head[q]  <= '0;
                tail[q]  <= '0;
                count[q] <= '0;
            end
            room      <= '0;
            ret_valid <= 1'b0;
        end
        else
        begin
            for (int q = 0; q < NQ; q++)
            begin
                count[q] <= cnt_nxt[q];
                room[q]  <= (cnt_nxt[q] != REGION_WORDS);
                if (push[q])
                begin
                    tail[q] <= tail[q] + 1'b1;
                end
                if (rd_inc[q])
                begin
                    head[q] <= head[q] + 1'b1;
                end
            end
            // lines up with the memory read latency
            ret_valid <= |rd_inc;
        end
    end

    always_ff @(posedge memclk)
    begin
        ret_queue_id <= rd_q;
    end

    // the arbiter only grants regions that hold data
    a_no_empty_read: assert property (@(posedge memclk) disable iff (reset)
        (rd_inc & mem_empty) == '0);

endmodule

// ==== fifo_read_arbiter.sv ====
// round-robin burst arbiter over ready queues and steering of returned words
module fifo_read_arbiter
#(
    // reads from one queue before moving on
    parameter int BURST_LEN = 4
)
(
    input  logic                        memclk,
    input  logic                        reset,
    input  sram_fifo_pkg::queue_mask_t  mem_empty,
    input  sram_fifo_pkg::queue_mask_t  out_full,
    input  logic                        ret_valid,
    input  sram_fifo_pkg::queue_id_t    ret_queue_id,
    input  sram_fifo_pkg::word_t        ret_word,
    output sram_fifo_pkg::queue_mask_t  rd_inc,
    output sram_fifo_pkg::queue_mask_t  wr_valid,
    output sram_fifo_pkg::word_t        wr_word0,
    output sram_fifo_pkg::word_t        wr_word1,
    output sram_fifo_pkg::word_t        wr_word2,
    output sram_fifo_pkg::word_t        wr_word3
);

    localparam int NQ   = sram_fifo_pkg::NUM_QUEUES;
    localparam int BC_W = $clog2(BURST_LEN + 1);

    sram_fifo_pkg::queue_mask_t ready;
    sram_fifo_pkg::queue_id_t   cur;
    sram_fifo_pkg::queue_id_t   nxt_q;
    logic                       found;
    logic                       burst_done;
    logic [BC_W-1:0]            burst_cnt;
    sram_fifo_pkg::word_t       word_r [NQ];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // queue selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // data in memory and room downstream
    assign ready = ~mem_empty & ~out_full;

    // one read per cycle while the current queue stays ready
    always_comb
    begin
        rd_inc      = '0;
        rd_inc[cur] = ready[cur];
    end

    assign burst_done = ready[cur] && (burst_cnt == BC_W'(BURST_LEN - 1));

    // scan from cur+1 around to cur itself; wraps on the 2-bit add
    always_comb
    begin
        nxt_q = cur;
        found = 1'b0;
        for (int i = 1; i <= NQ; i++)
        begin
            if (!found && ready[cur + sram_fifo_pkg::queue_id_t'(i)])
            begin
                nxt_q = cur + sram_fifo_pkg::queue_id_t'(i);
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge memclk)
    begin
        if (reset)
        begin
            cur       <= '0;
            burst_cnt <= '0;
            wr_valid  <= '0;
        end
        else
        begin
            if (burst_done || !ready[cur])
            begin
                cur       <= nxt_q;
                burst_cnt <= '0;
            end
            else
            begin
                burst_cnt <= burst_cnt + 1'b1;
            end
            // egress write one cycle behind the returned word
            wr_valid <= ret_valid ? (sram_fifo_pkg::queue_mask_t'(1) << ret_queue_id) : '0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // return path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // only the addressed queue's holding register loads
    always_ff @(posedge memclk)
    begin
        for (int k = 0; k < NQ; k++)
        begin
            if (ret_valid && (ret_queue_id == k))
            begin
                word_r[k] <= ret_word;
            end
        end
    end

    assign wr_word0 = word_r[0];
    assign wr_word1 = word_r[1];
    assign wr_word2 = word_r[2];
    assign wr_word3 = word_r[3];

    a_rd_onehot: assert property (@(posedge memclk) disable iff (reset)
        $onehot0(rd_inc));

    // every grant comes back as an egress write two cycles later
    a_grant_returns: assert property (@(posedge memclk) disable iff (reset)
        (|rd_inc) |-> ##2 (|wr_valid));

endmodule

// ==== egress_queue.sv ====
// per-queue output FIFO with in-flight reservation counting for the full flag
module egress_queue
#(
    // entries, power of two
    parameter int OUT_DEPTH = 4
)
(
    input  logic                  memclk,
    input  logic                  reset,
    input  logic                  reserve,
    input  logic                  wr_valid,
    input  sram_fifo_pkg::word_t  wr_word,
    input  logic                  out_ready,
    output logic                  full,
    output logic                  out_valid,
    output sram_fifo_pkg::word_t  out_word
);

    localparam int PTR_W = $clog2(OUT_DEPTH);
    localparam int CNT_W = $clog2(OUT_DEPTH + 1);

    sram_fifo_pkg::word_t mem [OUT_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    // stored words
    logic [CNT_W-1:0]     count;
    // granted reads not yet written here
    logic [CNT_W-1:0]     resv;
    logic                 pop;

    assign pop       = out_valid & out_ready;
    assign out_valid = (count != '0);
    assign out_word  = mem[rd_ptr];
    // in-flight words hold their slot from grant onwards
    assign full      = ((count + resv) == OUT_DEPTH);

    always_ff @(posedge memclk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            resv   <= '0;
        end
        else
        begin
            if (wr_valid)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together keep the count
            count <= count + CNT_W'(wr_valid) - CNT_W'(pop);
            // a reservation turns into a stored word at wr_valid
            resv  <= resv + CNT_W'(reserve) - CNT_W'(wr_valid);
        end
    end

    always_ff @(posedge memclk)
    begin
        if (wr_valid)
        begin
            mem[wr_ptr] <= wr_word;
        end
    end

    a_no_overflow: assert property (@(posedge memclk) disable iff (reset)
        !(wr_valid && (count == OUT_DEPTH)));

endmodule

// ==== sram_fifo_top.sv ====
// top level: pointer control, storage, read arbiter and per-queue egress FIFOs
module sram_fifo_top
#(
    parameter int REGION_LOG2 = 4,
    parameter int BURST_LEN   = 4,
    parameter int OUT_DEPTH   = 4
)
(
    input  logic                        memclk,
    input  logic                        reset,
    input  logic                        in_valid,
    input  sram_fifo_pkg::word_t        in_word,
    input  sram_fifo_pkg::queue_id_t    in_queue_id,
    input  sram_fifo_pkg::queue_mask_t  out_ready,
    output logic                        in_ready,
    output sram_fifo_pkg::queue_mask_t  out_valid,
    output sram_fifo_pkg::word_t        out_word0,
    output sram_fifo_pkg::word_t        out_word1,
    output sram_fifo_pkg::word_t        out_word2,
    output sram_fifo_pkg::word_t        out_word3
);

    localparam int NQ     = sram_fifo_pkg::NUM_QUEUES;
    localparam int ADDR_W = REGION_LOG2 + sram_fifo_pkg::QID_W;

    sram_fifo_pkg::queue_mask_t mem_empty;
    sram_fifo_pkg::queue_mask_t out_full;
    sram_fifo_pkg::queue_mask_t rd_inc;
    sram_fifo_pkg::queue_mask_t wr_valid;
    sram_fifo_pkg::word_t       wr_word  [NQ];
    sram_fifo_pkg::word_t       out_word [NQ];
    logic                       mem_wr_en;
    logic [ADDR_W-1:0]          mem_wr_addr;
    logic [ADDR_W-1:0]          mem_rd_addr;
    sram_fifo_pkg::word_t       mem_wr_word;
    sram_fifo_pkg::word_t       ret_word;
    logic                       ret_valid;
    sram_fifo_pkg::queue_id_t   ret_queue_id;

    queue_pointer_ctrl #(.REGION_LOG2(REGION_LOG2)) u_queue_pointer_ctrl (
        .memclk(memclk), .reset(reset), .in_valid(in_valid), .in_word(in_word),
        .in_queue_id(in_queue_id), .rd_inc(rd_inc), .in_ready(in_ready),
        .mem_empty(mem_empty), .mem_wr_en(mem_wr_en), .mem_wr_addr(mem_wr_addr),
        .mem_wr_word(mem_wr_word), .mem_rd_addr(mem_rd_addr),
        .ret_valid(ret_valid), .ret_queue_id(ret_queue_id));

    sram_bank #(.REGION_LOG2(REGION_LOG2)) u_sram_bank (
        .memclk(memclk), .wr_en(mem_wr_en), .wr_addr(mem_wr_addr),
        .wr_word(mem_wr_word), .rd_addr(mem_rd_addr), .rd_word(ret_word));

    fifo_read_arbiter #(.BURST_LEN(BURST_LEN)) u_fifo_read_arbiter (
        .memclk(memclk), .reset(reset), .mem_empty(mem_empty), .out_full(out_full),
        .ret_valid(ret_valid), .ret_queue_id(ret_queue_id), .ret_word(ret_word),
        .rd_inc(rd_inc), .wr_valid(wr_valid), .wr_word0(wr_word[0]),
        .wr_word1(wr_word[1]), .wr_word2(wr_word[2]), .wr_word3(wr_word[3]));

    // one output FIFO per queue
    for (genvar g = 0; g < NQ; g++)
    begin : g_egress
        egress_queue #(.OUT_DEPTH(OUT_DEPTH)) u_egress_queue (
            .memclk(memclk), .reset(reset), .reserve(rd_inc[g]),
            .wr_valid(wr_valid[g]), .wr_word(wr_word[g]), .out_ready(out_ready[g]),
            .full(out_full[g]), .out_valid(out_valid[g]), .out_word(out_word[g]));
    end

    assign out_word0 = out_word[0];
    assign out_word1 = out_word[1];
    assign out_word2 = out_word[2];
    assign out_word3 = out_word[3];

endmodule

// ==== tb_sram_fifo.sv ====
// directed testbench with clock, reset, watchdog, reference queues, push and drain tasks and checks
module tb_sram_fifo;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int REGION_LOG2 = 4;
    localparam int BURST_LEN   = 4;
    localparam int OUT_DEPTH   = 4;
    localparam int NQ          = sram_fifo_pkg::NUM_QUEUES;
    localparam int PERIOD      = 100;
    // cycle budgets of reset and each test summed for the watchdog
    localparam int WATCHDOG_CYCLES = 20 + 300 + 600 + 1200 + 600 + 3000;

    logic                       memclk;
    logic                       reset;
    logic                       in_valid;
    sram_fifo_pkg::word_t       in_word;
    sram_fifo_pkg::queue_id_t   in_queue_id;
    sram_fifo_pkg::queue_mask_t out_ready;
    logic                       in_ready;
    sram_fifo_pkg::queue_mask_t out_valid;
    sram_fifo_pkg::word_t       out_word0;
    sram_fifo_pkg::word_t       out_word1;
    sram_fifo_pkg::word_t       out_word2;
    sram_fifo_pkg::word_t       out_word3;

    integer seed;
    bit     rand_ready;
    // expected words per queue in push order
    sram_fifo_pkg::word_t exp_q [NQ][$];

    sram_fifo_top #(.REGION_LOG2(REGION_LOG2), .BURST_LEN(BURST_LEN), .OUT_DEPTH(OUT_DEPTH))
    u_sram_fifo_top (
        .memclk(memclk), .reset(reset), .in_valid(in_valid), .in_word(in_word),
        .in_queue_id(in_queue_id), .out_ready(out_ready), .in_ready(in_ready),
        .out_valid(out_valid), .out_word0(out_word0), .out_word1(out_word1),
        .out_word2(out_word2), .out_word3(out_word3));

    always #(PERIOD / 2) memclk = ~memclk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic report_fail();
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input sram_fifo_pkg::word_t got, input sram_fifo_pkg::word_t exp,
                              input string msg);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns: %s: got %h expected %h", $time, msg, got, exp);
            report_fail();
        end
    endtask

    task automatic check_queue(input sram_fifo_pkg::queue_id_t got,
                               input sram_fifo_pkg::queue_id_t exp, input string msg);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns: %s: got %0d expected %0d", $time, msg, got, exp);
            report_fail();
        end
    endtask

    task automatic check_mask(input sram_fifo_pkg::queue_mask_t got,
                              input sram_fifo_pkg::queue_mask_t exp, input string msg);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns: %s: got %b expected %b", $time, msg, got, exp);
            report_fail();
        end
    endtask

    // four-state so an unknown flag cannot pass as zero
    task automatic check_count(input integer got, input integer exp, input string msg);
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns: %s: got %0d expected %0d", $time, msg, got, exp);
            report_fail();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // random word with the queue number in the top data bits
    function automatic sram_fifo_pkg::word_t make_word(input sram_fifo_pkg::queue_id_t q);
        sram_fifo_pkg::data_t d;
        sram_fifo_pkg::user_t u;
        logic                 last;
        d    = $random(seed);
        u    = $random(seed);
        last = $random(seed);
        d[sram_fifo_pkg::DATA_W-1 -: sram_fifo_pkg::QID_W] = q;
        return {last, u, d};
    endfunction

    function automatic sram_fifo_pkg::word_t port_word(input int q);
        case (q)
            0:       return out_word0;
            1:       return out_word1;
            2:       return out_word2;
            default: return out_word3;
        endcase
    endfunction

    // any expected word left on the queues in m
    function automatic bit pending(input sram_fifo_pkg::queue_mask_t m);
        for (int q = 0; q < NQ; q++)
        begin
            if (m[q] && exp_q[q].size() != 0)
            begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // advance to the drive point 5 ns after the rising edge
    task automatic step_cycle();
        @(posedge memclk);
        #5;
        if (rand_ready)
        begin
            out_ready = sram_fifo_pkg::queue_mask_t'($random(seed));
        end
    endtask

    // offer one word and give up after max_wait cycles without in_ready
    task automatic push_word(input sram_fifo_pkg::queue_id_t q, input int max_wait,
                             output int taken);
        sram_fifo_pkg::word_t w;
        int                   n;
        w           = make_word(q);
        in_valid    = 1'b1;
        in_word     = w;
        in_queue_id = q;
        taken       = 0;
        n           = 0;
        while (!taken && n < max_wait)
        begin
            @(negedge memclk);
            if (in_ready)
            begin
                taken = 1;
                exp_q[q].push_back(w);
            end
            step_cycle();
            n++;
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_drain(input sram_fifo_pkg::queue_mask_t m, input int max_cycles);
        int n;
        n = 0;
        while (pending(m) && n < max_cycles)
        begin
            step_cycle();
            n++;
        end
        if (pending(m))
        begin
            $display("queues %b did not drain within %0d cycles", m, max_cycles);
            report_fail();
        end
    endtask

    // egress monitor samples the handshake at the falling edge where it is stable
    always @(negedge memclk)
    begin
        sram_fifo_pkg::word_t got;
        sram_fifo_pkg::word_t exp;
        if (!reset)
        begin
            for (int q = 0; q < NQ; q++)
            begin
                if (out_valid[q] && out_ready[q])
                begin
                    got = port_word(q);
                    if (exp_q[q].size() == 0)
                    begin
                        $display("unexpected word %h on the output of queue %0d", got, q);
                        report_fail();
                    end
                    else
                    begin
                        // routing first, so a word on the wrong port is named as such
                        check_queue(got[sram_fifo_pkg::DATA_W-1 -: sram_fifo_pkg::QID_W],
                                    sram_fifo_pkg::queue_id_t'(q), "queue number in word");
                        exp = exp_q[q].pop_front();
                        check_word(got, exp, $sformatf("queue %0d output word", q));
                    end
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic order_on_one_queue();
        int t;
        out_ready = '1;
        for (int i = 0; i < 12; i++)
        begin
            push_word(1, 50, t);
            check_count(t, 1, "push to queue 1 accepted");
        end
        wait_drain('1, 200);
    endtask

    task automatic route_by_queue();
        int t;
        for (int i = 0; i < 40; i++)
        begin
            push_word(sram_fifo_pkg::queue_id_t'(i % NQ), 50, t);
            check_count(t, 1, "interleaved push accepted");
        end
        wait_drain('1, 300);
    endtask

    // with queue 2 stalled its region and egress FIFO fill while other queues still accept
    task automatic fill_stalled_queue();
        int t;
        int accepted;
        out_ready = 4'b1011;
        accepted  = 0;
        t         = 1;
        while (t)
        begin
            push_word(2, 30, t);
            accepted += t;
        end
        check_count(accepted, 2 ** REGION_LOG2 + OUT_DEPTH, "words taken by stalled queue 2");
        in_queue_id = 2;
        @(negedge memclk);
        check_count(in_ready, 0, "in_ready for full queue 2");
        step_cycle();
        for (int i = 0; i < 12; i++)
        begin
            push_word(sram_fifo_pkg::queue_id_t'((i % 3 == 2) ? 3 : i % 3), 50, t);
            check_count(t, 1, "push to a free queue accepted");
        end
    endtask

    task automatic drain_around_stall();
        wait_drain(4'b1011, 300);
        // the other queues are empty and queue 2 still offers its held words
        @(negedge memclk);
        check_mask(out_valid, 4'b0100, "out_valid with only queue 2 holding words");
        step_cycle();
        out_ready = '1;
        wait_drain('1, 300);
    endtask

    task automatic random_back_pressure();
        int t;
        rand_ready = 1'b1;
        for (int i = 0; i < 150; i++)
        begin
            push_word(sram_fifo_pkg::queue_id_t'($random(seed)), 200, t);
            check_count(t, 1, "push under random back-pressure accepted");
        end
        rand_ready = 1'b0;
        out_ready  = '1;
        wait_drain('1, 500);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // run
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial
    begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("watchdog: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        report_fail();
    end

    initial
    begin
        seed        = 32'h5269;
        memclk      = 1'b0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_word     = '0;
        in_queue_id = '0;
        out_ready   = '0;
        rand_ready  = 1'b0;
        repeat (16) @(posedge memclk);
        #5;
        reset = 1'b0;
        // still the reset state until the next edge
        @(negedge memclk);
        check_count(in_ready, 0, "in_ready after reset");
        check_mask(out_valid, '0, "out_valid after reset");
        step_cycle();
        order_on_one_queue();
        route_by_queue();
        fill_stalled_queue();
        drain_around_stall();
        random_back_pressure();
        if (pending('1))
        begin
            $display("expected words left over at end of run");
            report_fail();
        end
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== build.f ====
sram_fifo_pkg.sv
sram_bank.sv
queue_pointer_ctrl.sv
fifo_read_arbiter.sv
egress_queue.sv
sram_fifo_top.sv
tb_sram_fifo.sv
